/* tb.f */
hdl/cpu_pkg.sv
hdl/bus_sequencer.sv
hdl/register_file.sv
hdl/alu8.sv
hdl/control_unit.sv
hdl/lr35902_core.sv
tb/bus_asserts.sv
tb/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the LR35902-style core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top \
	--Mdir obj_dir -o tb_sim; then
	echo "Compilation failed"
	exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
	import cpu_pkg::*;

	localparam int SEED        = 32'h61eb7707;
	localparam int PROG_LEN    = 35;                  // Bytes of the directed program at 0x0000
	localparam int PROG_INSTRS = 26;                  // Instructions in the directed program
	localparam int N_FETCH     = PROG_INSTRS + 2000;  // Directed part plus the random stream
	localparam int HALT_AT     = 1000;                // Opcode fetch where the halt test starts
	localparam int HALT_SETTLE = 20;                  // Longest instruction is 16 clocks
	localparam int HALT_HOLD   = 40;
	localparam int TIMEOUT_NS  = N_FETCH * 4 * 4 * 8 + (2 * HALT_SETTLE + HALT_HOLD) * 8 + 4000;

	logic   clk;
	logic   reset;
	logic   halt;
	byte_t  din;
	addr_t  adr;
	byte_t  dout;
	addr_t  pc;
	logic   read, write, ddrv;
	flags_t f;

	byte_t mem [65536];        // Memory seen by the DUT
	byte_t model_mem [65536];  // Memory as the reference model sees it
	byte_t model_regs [8];     // B C D E H L at 0..5 and A at 7
	addr_t model_pc;
	flags_t model_f;
	logic [23:0] exp_writes [$];  // Address and data of every store the model predicts
	logic [23:0] w;

	int value_errors;
	int other_errors;
	int fetch_count;  // Opcode fetches seen so far and so instructions started
	int read_count;   // Every rising edge of read
	int write_count;
	int skip_reads;   // Operand reads still due before the next opcode
	logic read_prev;

	// Five LD r,d8, the ALU ops, INC, DEC, CPL, SCF, SBC, CP and then a dump through HL
	byte_t prog [PROG_LEN] = '{
		8'h06, 8'h12, 8'h0e, 8'h34, 8'h16, 8'h56, 8'h1e, 8'h78, 8'h3e, 8'h9a,
		8'h80, 8'h91, 8'ha2, 8'hab, 8'hb3, 8'hce, 8'h05, 8'h3c, 8'h0d, 8'h2f,
		8'h37, 8'h9f, 8'hfe, 8'h10, 8'h26, 8'hc0, 8'h2e, 8'h10,
		8'h70, 8'h71, 8'h72, 8'h73, 8'h74, 8'h75, 8'h77
	};

	lr35902_core lr35902_core_i (
		.clk(clk), .reset(reset), .halt(halt), .din(din), .adr(adr), .dout(dout),
		.pc(pc), .read(read), .write(write), .ddrv(ddrv), .f(f)
	);

	always #4 clk = ~clk;  // 8 ns period

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			value_errors++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Branch conditions as the instruction set defines them
	function automatic logic cond_met(byte_t op);
		case (op)
			8'h18, 8'hc3: return 1'b1;
			8'h20, 8'hc2: return !model_f[3];  // NZ
			8'h28, 8'hca: return model_f[3];   // Z
			8'h30, 8'hd2: return !model_f[0];  // NC
			8'h38, 8'hda: return model_f[0];   // C
			default:      return 1'b0;
		endcase
	endfunction

	// Accumulator operation on plain integers with the flags rebuilt from scratch
	function automatic void apply_alu(logic [2:0] code, byte_t operand);
		int a;
		int b;
		int c;
		int r;
		logic hf;
		logic cf;
		logic nf;
		a  = model_regs[7];
		b  = operand;
		c  = model_f[0];
		hf = 1'b0;
		cf = 1'b0;
		nf = 1'b0;
		case (code)
			3'd0, 3'd1:
			begin
				if (code == 3'd0)
					c = 0;  // Plain ADD ignores the carry
				r  = a + b + c;
				hf = (a % 16) + (b % 16) + c > 15;
				cf = r > 255;
			end
			3'd2, 3'd3, 3'd7:
			begin
				if (code != 3'd3)
					c = 0;  // Only SBC borrows in
				r  = a - b - c;
				hf = (a % 16) < (b % 16) + c;
				cf = a < b + c;
				nf = 1'b1;
			end
			3'd4:
			begin
				r  = a & b;
				hf = 1'b1;
			end
			3'd5: r = a ^ b;
			default: r = a | b;
		endcase
		if (code != 3'd7)
			model_regs[7] = byte_t'(r);  // Compare keeps A
		model_f = {byte_t'(r) == 8'd0, nf, hf, cf};
	endfunction

	// Runs one instruction on the model and returns the operand reads that follow the opcode
	function automatic int step_model();
		byte_t op;
		byte_t val;
		byte_t lo;
		byte_t hi;
		addr_t hl;
		int extra;
		hl       = {model_regs[4], model_regs[5]};
		op       = model_mem[model_pc];
		model_pc = model_pc + 16'd1;
		extra    = 0;
		if (op[7:6] == 2'b01 && op != 8'h76)
		begin
			if (op[2:0] == 3'd6)
			begin
				model_regs[op[5:3]] = model_mem[hl];  // LD r,(HL)
				extra = 1;
			end
			else if (op[5:3] == 3'd6)
			begin
				exp_writes.push_back({hl, model_regs[op[2:0]]});  // LD (HL),r
				model_mem[hl] = model_regs[op[2:0]];
			end
			else
				model_regs[op[5:3]] = model_regs[op[2:0]];
		end
		else if (op[7:6] == 2'b00 && op[2:0] == 3'd6 && op[5:3] != 3'd6)
		begin
			model_regs[op[5:3]] = model_mem[model_pc];  // LD r,d8
			model_pc = model_pc + 16'd1;
			extra = 1;
		end
		else if (op[7:6] == 2'b10 || (op[7:6] == 2'b11 && op[2:0] == 3'd6))
		begin
			if (op[2:0] != 3'd6)
				val = model_regs[op[2:0]];
			else if (op[6])
			begin
				val = model_mem[model_pc];  // Immediate form
				model_pc = model_pc + 16'd1;
				extra = 1;
			end
			else
			begin
				val = model_mem[hl];
				extra = 1;
			end
			apply_alu(op[5:3], val);
		end
		else if (op[7:6] == 2'b00 && op[2:1] == 2'b10 && op[5:3] != 3'd6)
		begin
			val = model_regs[op[5:3]];
			if (op[0])
				model_regs[op[5:3]] = val - 8'd1;
			else
				model_regs[op[5:3]] = val + 8'd1;
			// Carry stays as it was
			model_f[3:1] = {model_regs[op[5:3]] == 8'd0, op[0],
				op[0] ? val[3:0] == 4'h0 : val[3:0] == 4'hf};
		end
		else if (op == 8'h2f)
		begin
			model_regs[7] = ~model_regs[7];
			model_f[2:1] = 2'b11;
		end
		else if (op == 8'h37 || op == 8'h3f)
			model_f[2:0] = {2'b00, op == 8'h37 ? 1'b1 : !model_f[0]};
		else if (op inside {8'hc3, 8'hc2, 8'hca, 8'hd2, 8'hda})
		begin
			lo = model_mem[model_pc];
			hi = model_mem[model_pc + 16'd1];
			model_pc = model_pc + 16'd2;
			extra = 2;
			if (cond_met(op))
				model_pc = {hi, lo};
		end
		else if (op inside {8'h18, 8'h20, 8'h28, 8'h30, 8'h38})
		begin
			lo = model_mem[model_pc];
			model_pc = model_pc + 16'd1;
			extra = 1;
			if (cond_met(op))
				model_pc = model_pc + {{8{lo[7]}}, lo};  // Offset counts from the next opcode
		end
		return extra;  // Anything else behaves as NOP
	endfunction

	// Memory model that puts one byte out per clock and commits stores on the write strobe
	always @(posedge clk)
	begin
		din <= mem[adr];
		if (write)
			mem[adr] <= dout;
	end

	// Steps the model at every opcode fetch and compares the bus against it
	always @(posedge clk)
	begin
		if (reset)
			read_prev <= 1'b0;
		else
		begin
			read_prev <= read;
			if (write)
			begin
				write_count++;
				if (exp_writes.size() == 0)
				begin
					other_errors++;
					$display("Write to %h with data %h that no instruction asked for", adr, dout);
				end
				else
				begin
					w = exp_writes.pop_front();
					check_value("store_adr", 32'(w[23:8]), 32'(adr));
					check_value("store_data", 32'(w[7:0]), 32'(dout));
				end
			end
			if (read && !read_prev)
			begin
				read_count++;
				if (skip_reads > 0)
					skip_reads--;  // Immediate or (HL) operand
				else
				begin
					if (fetch_count == 0)
						check_value("reset_adr", 32'h0, 32'(adr));
					check_value("fetch_adr", 32'(model_pc), 32'(adr));
					check_value("fetch_pc", addr_t'(model_pc + 16'd1), 32'(pc));  // PC is past the opcode
					check_value("flags", 32'(model_f), 32'(f));
					skip_reads = step_model();
					fetch_count++;
				end
			end
		end
	end

	task automatic wait_fetches(input int n);
		while (fetch_count < n)
			@(posedge clk);
	endtask

	initial
	begin
		int a;
		int n;
		void'($urandom(SEED));
		clk          = 1'b0;
		reset        = 1'b1;
		halt         = 1'b0;
		din          = '0;
		value_errors = 0;
		other_errors = 0;
		fetch_count  = 0;
		read_count   = 0;
		write_count  = 0;
		skip_reads   = 0;
		model_pc     = '0;
		model_f      = '0;
		for (a = 0; a < 8; a++)
			model_regs[a] = '0;
		for (a = 0; a < 65536; a++)
			mem[a] = byte_t'($urandom);
		for (a = 0; a < PROG_LEN; a++)
			mem[a] = prog[a];
		for (a = 0; a < 65536; a++)
			model_mem[a] = mem[a];

		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_value("reset_read", 32'h0, 32'(read));
		check_value("reset_write", 32'h0, 32'(write));
		check_value("reset_ddrv", 32'h0, 32'(ddrv));

		// All seven registers are stored once the first random opcode is fetched
		wait_fetches(PROG_INSTRS + 1);
		check_value("dump_writes", 32'd7, 32'(write_count));

		wait_fetches(HALT_AT);
		halt <= 1'b1;
		repeat (HALT_SETTLE) @(posedge clk);  // Current instruction runs to its end
		n = read_count;
		repeat (HALT_HOLD) @(posedge clk);
		if (read_count != n)
		begin
			other_errors++;
			$display("The core read from the bus while halt was held");
		end
		halt <= 1'b0;

		// Park the core on halt so every store of the last instructions has landed
		wait_fetches(N_FETCH);
		halt <= 1'b1;
		repeat (HALT_SETTLE) @(posedge clk);
		if (exp_writes.size() != 0)
		begin
			other_errors++;
			$display("%0d predicted stores never reached the bus", exp_writes.size());
		end

		$display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
			value_errors, other_errors, lr35902_core_i.bus_sequencer_i.bus_asserts_i.fail_count);
		if (value_errors == 0 && other_errors == 0 &&
			lr35902_core_i.bus_sequencer_i.bus_asserts_i.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Worst case is four machine cycles of four clocks for every instruction
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the core did not reach the end of the instruction stream in time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* tb/bus_asserts.sv */
`timescale 1ns/1ps

module bus_asserts (
	input logic            clk,
	input logic            reset,
	input logic            read,
	input logic            write,
	input logic            ddrv,
	input logic            step_end,
	input cpu_pkg::phase_t phase
);
	import cpu_pkg::*;

	int fail_count = 0;  // Assertion failures so far

	// The bus carries one transfer direction at a time
	read_write_apart: assert property (@(posedge clk) disable iff (reset) !(read && write))
	else
	begin
		$error("read and write are high together");
		fail_count++;
	end

	// Data must be on the bus for the whole write strobe
	write_driven: assert property (@(posedge clk) disable iff (reset) write |-> ddrv)
	else
	begin
		$error("write is high while ddrv is low");
		fail_count++;
	end

	// A step ends in the last phase after the request and latch phases ran in order
	step_in_last_phase: assert property (@(posedge clk) disable iff (reset)
		step_end |-> phase == PHASE_LAST && $past(phase) == PHASE_LATCH
			&& $past(phase, 2) == PHASE_REQ)
	else
	begin
		$error("step_end without a full run of phases before it");
		fail_count++;
	end

endmodule

bind bus_sequencer bus_asserts bus_asserts_i (.*);

/* hdl/lr35902_core.sv */
`timescale 1ns/1ps

module lr35902_core (
	input  logic            clk,
	input  logic            reset,
	input  logic            halt,
	input  cpu_pkg::byte_t  din,
	output cpu_pkg::addr_t  adr,
	output cpu_pkg::byte_t  dout,
	output cpu_pkg::addr_t  pc,
	output logic            read,
	output logic            write,
	output logic            ddrv,
	output cpu_pkg::flags_t f
);
	import cpu_pkg::*;

	cpu_state_t state;
	phase_t     phase;
	logic       step_end;
	reg_sel_t   src_sel, dst_sel, wr_sel;
	logic       wr_en;
	byte_t      wr_data, src_val, dst_val, acc;
	addr_t      hl;
	byte_t      operand, result, incdec_result;
	flags_t     flags_out;
	logic [2:0] alu_op, incdec_flags;
	logic       dec;

	// Four-clock machine cycle and the bus strobes
	bus_sequencer bus_sequencer_i (
		.clk(clk), .reset(reset), .halt(halt), .state(state), .phase(phase),
		.step_end(step_end), .read(read), .write(write), .ddrv(ddrv)
	);

	register_file register_file_i (
		.clk(clk), .reset(reset), .src_sel(src_sel), .dst_sel(dst_sel), .wr_sel(wr_sel),
		.wr_en(wr_en), .wr_data(wr_data), .src_val(src_val), .dst_val(dst_val),
		.acc(acc), .hl(hl)
	);

	// INC and DEC read their operand from the destination port directly
	alu8 alu8_i (
		.acc(acc), .operand(operand), .incdec_operand(dst_val), .alu_op(alu_op),
		.dec(dec), .carry_in(f[FLAG_C]), .result(result), .incdec_result(incdec_result),
		.flags_out(flags_out), .incdec_flags(incdec_flags)
	);

	control_unit control_unit_i (
		.clk(clk), .reset(reset), .phase(phase), .step_end(step_end), .din(din),
		.state(state), .adr(adr), .dout(dout), .pc(pc), .f(f),
		.src_sel(src_sel), .dst_sel(dst_sel), .wr_sel(wr_sel), .wr_en(wr_en),
		.wr_data(wr_data), .src_val(src_val), .acc(acc), .hl(hl), .operand(operand),
		.alu_op(alu_op), .dec(dec), .result(result), .flags_out(flags_out),
		.incdec_result(incdec_result), .incdec_flags(incdec_flags)
	);

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
	input  logic                clk,
	input  logic                reset,
	input  cpu_pkg::phase_t     phase,
	input  logic                step_end,
	input  cpu_pkg::byte_t      din,
	output cpu_pkg::cpu_state_t state,
	output cpu_pkg::addr_t      adr,
	output cpu_pkg::byte_t      dout,
	output cpu_pkg::addr_t      pc,
	output cpu_pkg::flags_t     f,
	output cpu_pkg::reg_sel_t   src_sel,
	output cpu_pkg::reg_sel_t   dst_sel,
	output cpu_pkg::reg_sel_t   wr_sel,
	output logic                wr_en,
	output cpu_pkg::byte_t      wr_data,
	input  cpu_pkg::byte_t      src_val,
	input  cpu_pkg::byte_t      acc,
	input  cpu_pkg::addr_t      hl,
	output cpu_pkg::byte_t      operand,
	output logic [2:0]          alu_op,
	output logic                dec,
	input  cpu_pkg::byte_t      result,
	input  cpu_pkg::flags_t     flags_out,
	input  cpu_pkg::byte_t      incdec_result,
	input  logic [2:0]          incdec_flags
);
	import cpu_pkg::*;

	byte_t      op;          // Current opcode
	byte_t      imml;        // Immediate low byte, also the byte read from (HL)
	byte_t      immh;        // Immediate high byte of JP
	cpu_state_t next_state;
	flags_t     f_next;
	logic       pc_load;
	addr_t      pc_next;
	addr_t      jr_target;
	logic       pc_fetch;    // Steps that read at the PC and advance it
	logic       is_ld, is_ld_imm, is_alu, is_incdec, is_jp, is_jr;
	logic       taken;

	// Operand fields come straight from the opcode
	assign src_sel = op[2:0];
	assign dst_sel = op[5:3];
	assign alu_op  = op[5:3];
	assign dec     = op[0];
	assign operand = (src_sel == SEL_MEM) ? imml : src_val;  // (HL) and d8 both land in imml

	// Instruction classes, everything else falls through as NOP
	assign is_ld     = op[7:6] == 2'b01 && op != OP_HALT;
	assign is_ld_imm = op[7:6] == 2'b00 && op[2:0] == SEL_MEM && op[5:3] != SEL_MEM;
	assign is_alu    = op[7:6] == 2'b10 || (op[7:6] == 2'b11 && op[2:0] == SEL_MEM);
	assign is_incdec = op[7:6] == 2'b00 && op[2:1] == 2'b10 && op[5:3] != SEL_MEM;
	assign is_jp     = op == OP_JP || (op[7:5] == 3'b110 && op[2:0] == 3'b010);
	assign is_jr     = op == OP_JR || (op[7:5] == 3'b001 && op[2:0] == 3'b000);

	// Bit 4 picks C or Z and bit 3 gives the value that takes the branch
	assign taken = op == OP_JP || op == OP_JR || f[op[4] ? FLAG_C : FLAG_Z] == op[3];

	// Relative target uses its own adder, PC already points past the offset
	assign jr_target = pc + {{8{imml[7]}}, imml};
	assign pc_fetch  = state inside {IFETCH, IMM_FETCH, IMMH_FETCH};

	// Decide the next step and the write-back, applied only on step_end
	always_comb
	begin
		next_state = IFETCH;  // Most steps finish the instruction
		wr_en      = 1'b0;
		wr_sel     = op[5:3];
		wr_data    = operand;
		f_next     = f;
		pc_load    = 1'b0;
		pc_next    = jr_target;
		if (is_ld)
		begin
			if (op[2:0] == SEL_MEM)
			begin
				if (state == IFETCH)
					next_state = MEM_FETCH;  // Load from (HL) needs a bus read first
				else
					wr_en = step_end;
			end
			else if (op[5:3] == SEL_MEM)
			begin
				if (state == IFETCH)
					next_state = MEM_STORE;  // Address and data latched below
			end
			else
				wr_en = step_end;
		end
		else if (is_ld_imm)
		begin
			if (state == IFETCH)
				next_state = IMM_FETCH;
			else
				wr_en = step_end;
		end
		else if (is_alu)
		begin
			if (state == IFETCH && op[2:0] == SEL_MEM)
				next_state = op[6] ? IMM_FETCH : MEM_FETCH;  // Bit 6 marks the d8 form
			else
			begin
				wr_sel  = SEL_A;
				wr_data = result;
				wr_en   = step_end && alu_op != ALU_CP;  // Compare only updates flags
				f_next  = flags_out;
			end
		end
		else if (is_incdec)
		begin
			wr_data = incdec_result;
			wr_en   = step_end;
			{f_next[FLAG_Z], f_next[FLAG_N], f_next[FLAG_H]} = incdec_flags;
		end
		else if (op == OP_CPL)
		begin
			wr_sel         = SEL_A;
			wr_data        = ~acc;
			wr_en          = step_end;
			f_next[FLAG_N] = 1'b1;
			f_next[FLAG_H] = 1'b1;
		end
		else if (op == OP_SCF || op == OP_CCF)
		begin
			f_next[FLAG_N] = 1'b0;
			f_next[FLAG_H] = 1'b0;
			f_next[FLAG_C] = (op == OP_SCF) ? 1'b1 : ~f[FLAG_C];
		end
		else if (is_jp || is_jr)
		begin
			case (state)
				IFETCH:
					next_state = IMM_FETCH;
				IMM_FETCH:
				begin
					if (is_jp)
						next_state = IMMH_FETCH;
					else if (taken)
						next_state = JUMP;
				end
				IMMH_FETCH:
					if (taken)
						next_state = JUMP;
				JUMP:
				begin
					pc_load = 1'b1;  // Extra cycle spent only on a taken branch
					if (is_jp)
						pc_next = {immh, imml};
				end
				default:
					next_state = IFETCH;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IFETCH;
			op    <= '0;  // Decodes as NOP until the first opcode arrives
			pc    <= '0;
			f     <= '0;
			adr   <= '0;
		end
		else
		begin
			if (phase == PHASE_ADDR && pc_fetch)
				adr <= pc;
			if (phase == PHASE_REQ && pc_fetch)
				pc <= pc + 16'd1;
			if (phase == PHASE_LATCH)
			begin
				case (state)
					IFETCH:               op   <= din;
					IMM_FETCH, MEM_FETCH: imml <= din;
					IMMH_FETCH:           immh <= din;
					default:              op   <= op;
				endcase
			end
			if (step_end)
			begin
				state <= next_state;
				f     <= f_next;
				if (pc_load)
					pc <= pc_next;
				if (next_state == MEM_FETCH || next_state == MEM_STORE)
				begin
					adr  <= hl;       // Memory steps reuse the address set up here
					dout <= src_val;  // Only consumed by the store step
				end
			end
		end
	end

endmodule

/* hdl/alu8.sv */
`timescale 1ns/1ps

module alu8 (
	input  cpu_pkg::byte_t  acc,
	input  cpu_pkg::byte_t  operand,
	input  cpu_pkg::byte_t  incdec_operand,
	input  logic [2:0]      alu_op,
	input  logic            dec,
	input  logic            carry_in,
	output cpu_pkg::byte_t  result,
	output cpu_pkg::byte_t  incdec_result,
	output cpu_pkg::flags_t flags_out,
	output logic [2:0]      incdec_flags
);
	import cpu_pkg::*;

	logic [8:0] sum;    // Ninth bit is the carry or the borrow
	logic       sub;    // Subtract class sets N
	logic       hcarry;

	always_comb
	begin
		sum    = '0;
		sub    = 1'b0;
		hcarry = 1'b0;
		case (alu_op)
			ALU_ADD, ALU_ADC:
				sum = {1'b0, acc} + {1'b0, operand} + {8'd0, alu_op == ALU_ADC && carry_in};
			ALU_SUB, ALU_SBC, ALU_CP:
			begin
				// Only SBC pulls in the borrow, CP behaves like SUB
				sum = {1'b0, acc} - {1'b0, operand} - {8'd0, alu_op == ALU_SBC && carry_in};
				sub = 1'b1;
			end
			ALU_AND:
				sum = {1'b0, acc & operand};
			ALU_XOR:
				sum = {1'b0, acc ^ operand};
			ALU_OR:
				sum = {1'b0, acc | operand};
			default:
				sum = '0;
		endcase

		// Carry into bit 4 is recovered from the operand bits and the sum bit
		if (alu_op == ALU_AND)
			hcarry = 1'b1;
		else if (alu_op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP})
			hcarry = acc[4] ^ operand[4] ^ sum[4];
	end

	assign result    = sum[7:0];
	assign flags_out = {sum[7:0] == 8'd0, sub, hcarry, sum[8]};  // Logic ops leave sum[8] at zero

	// INC and DEC share one adder and never touch the carry
	assign incdec_result = dec ? incdec_operand - 8'd1 : incdec_operand + 8'd1;
	assign incdec_flags  = {incdec_result == 8'd0, dec, incdec_operand[4] ^ incdec_result[4]};

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::reg_sel_t src_sel,
	input  cpu_pkg::reg_sel_t dst_sel,
	input  cpu_pkg::reg_sel_t wr_sel,
	input  logic              wr_en,
	input  cpu_pkg::byte_t    wr_data,
	output cpu_pkg::byte_t    src_val,
	output cpu_pkg::byte_t    dst_val,
	output cpu_pkg::byte_t    acc,
	output cpu_pkg::addr_t    hl
);
	import cpu_pkg::*;

	// B C D E H L at 0..5 and A at 7, slot 6 is the memory operand and holds nothing
	byte_t regs [8];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_sel != SEL_MEM)
			regs[wr_sel] <= wr_data;  // Writes to the memory slot are dropped
	end

	// Source port follows opcode bits 2..0
	assign src_val = (src_sel == SEL_MEM) ? '0 : regs[src_sel];

	// Destination port follows opcode bits 5..3 and feeds INC and DEC
	assign dst_val = (dst_sel == SEL_MEM) ? '0 : regs[dst_sel];

	// Fixed taps for the accumulator and the memory pointer
	assign acc = regs[SEL_A];
	assign hl  = {regs[SEL_H], regs[SEL_L]};

endmodule

/* hdl/bus_sequencer.sv */
`timescale 1ns/1ps

module bus_sequencer (
	input  logic                clk,
	input  logic                reset,
	input  logic                halt,
	input  cpu_pkg::cpu_state_t state,
	output cpu_pkg::phase_t     phase,
	output logic                step_end,
	output logic                read,
	output logic                write,
	output logic                ddrv
);
	import cpu_pkg::*;

	logic stall;        // Hold the cycle before an opcode fetch starts
	logic fetch_state;  // States that read a byte from the bus
	logic store_state;  // State that drives a byte onto the bus

	// Halt only takes hold at the start of an opcode fetch
	assign stall       = halt && state == IFETCH && phase == PHASE_ADDR;
	assign fetch_state = state inside {IFETCH, IMM_FETCH, IMMH_FETCH, MEM_FETCH};
	assign store_state = state == MEM_STORE;

	// The control unit decides its next step on this pulse
	assign step_end = phase == PHASE_LAST;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= PHASE_ADDR;
			read  <= 1'b0;
			write <= 1'b0;
			ddrv  <= 1'b0;
		end
		else
		begin
			if (!stall)
				phase <= phase + 2'd1;  // Wraps from the last phase back to zero
			case (phase)
				PHASE_ADDR:
					ddrv <= store_state;  // Drive data only while a store is running
				PHASE_REQ:
				begin
					read  <= fetch_state;  // Read stays up through phases 2 and 3
					write <= store_state;  // Write is a one-clock strobe in phase 2
				end
				PHASE_LATCH:
					write <= 1'b0;
				PHASE_LAST:
					read <= 1'b0;  // Bus is idle again when the next cycle starts
			endcase
		end
	end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

	// Plain vector types for the widths that carry a meaning
	typedef logic [7:0]  byte_t;     // One data byte on the bus or in a register
	typedef logic [15:0] addr_t;     // Bus address and program counter
	typedef logic [3:0]  flags_t;    // Z N H C from high to low
	typedef logic [2:0]  reg_sel_t;  // Register index as coded in the opcode
	typedef logic [1:0]  phase_t;    // Clock position inside one machine cycle

	// Steps of an instruction, each of them one machine cycle long
	typedef enum logic [2:0] {IFETCH, IMM_FETCH, IMMH_FETCH, MEM_FETCH, MEM_STORE, JUMP} cpu_state_t;

	// Bit positions inside the flag nibble
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 2;
	localparam int FLAG_H = 1;
	localparam int FLAG_C = 0;

	// Register indices that the control logic names explicitly
	localparam reg_sel_t SEL_H   = 3'd4;
	localparam reg_sel_t SEL_L   = 3'd5;
	localparam reg_sel_t SEL_MEM = 3'd6;  // (HL) or the immediate byte
	localparam reg_sel_t SEL_A   = 3'd7;

	// Every machine cycle is four clocks, and the phase counter simply wraps
	localparam int MCYCLE_CLOCKS = 4;
	localparam phase_t PHASE_ADDR  = 2'd0;                          // Address goes out
	localparam phase_t PHASE_REQ   = 2'd1;                          // Read or write requested
	localparam phase_t PHASE_LATCH = 2'd2;                          // Data bus sampled
	localparam phase_t PHASE_LAST  = phase_t'(MCYCLE_CLOCKS - 1);  // Next step decided here

	// ALU operation codes, straight from opcode bits 5..3
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_ADC = 3'd1;
	localparam logic [2:0] ALU_SUB = 3'd2;
	localparam logic [2:0] ALU_SBC = 3'd3;
	localparam logic [2:0] ALU_AND = 3'd4;
	localparam logic [2:0] ALU_XOR = 3'd5;
	localparam logic [2:0] ALU_OR  = 3'd6;
	localparam logic [2:0] ALU_CP  = 3'd7;

	// Single opcodes that are decoded by their full value
	localparam byte_t OP_HALT = 8'h76;  // Runs as a plain NOP in this core
	localparam byte_t OP_CPL  = 8'h2f;
	localparam byte_t OP_SCF  = 8'h37;
	localparam byte_t OP_CCF  = 8'h3f;
	localparam byte_t OP_JP   = 8'hc3;  // Unconditional absolute jump
	localparam byte_t OP_JR   = 8'h18;  // Unconditional relative jump

endpackage
